/* axi_node_defines.svh */
`ifndef AXI_NODE_DEFINES_SVH
`define AXI_NODE_DEFINES_SVH

// Bus field widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32

// ID width as seen by the masters on the slave ports
`define AXI_ID_WIDTH 4

// Port counts
`define NB_SLAVE  2
`define NB_MASTER 3

`endif

/* axi_node_pkg.sv */
`include "axi_node_defines.svh"

package axi_node_pkg;

  // Slave port index is prepended to the ID toward the peripherals
  localparam int AXI_ID_WIDTH_INIT = `AXI_ID_WIDTH + $clog2(`NB_SLAVE);

  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_ID_WIDTH-1:0]   id_targ_t;
  typedef logic [AXI_ID_WIDTH_INIT-1:0] id_init_t;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  typedef struct packed {
    id_targ_t id;
    addr_t    addr;
  } ar_targ_t;

  typedef struct packed {
    id_init_t id;
    addr_t    addr;
  } ar_init_t;

  typedef struct packed {
    id_targ_t id;
    data_t    data;
    resp_e    resp;
  } r_targ_t;

  typedef struct packed {
    id_init_t id;
    data_t    data;
    resp_e    resp;
  } r_init_t;

endpackage

/* axi_addr_decoder.sv */
`include "axi_node_defines.svh"

module axi_addr_decoder
(
  input  logic                                    clk,
  input  logic                                    rst_n_i,

  input  axi_node_pkg::addr_t [`NB_MASTER-1:0]    start_addr_i,
  input  axi_node_pkg::addr_t [`NB_MASTER-1:0]    end_addr_i,

  input  logic                                    slave_ar_valid_i,
  input  axi_node_pkg::ar_targ_t                  slave_ar_i,
  output logic                                    slave_ar_ready_o,

  output logic [`NB_MASTER-1:0]                   req_o,
  output axi_node_pkg::ar_targ_t                  req_ar_o,
  input  logic [`NB_MASTER-1:0]                   gnt_i,

  output logic                                    err_r_valid_o,
  output axi_node_pkg::r_targ_t                   err_r_o,
  input  logic                                    err_r_ready_i
);

  import axi_node_pkg::*;

  logic [`NB_MASTER-1:0] hit;
  logic                  miss;
  logic                  err_accept;
  logic                  err_pending_q;
  id_targ_t              err_id_q;

  always_comb
  begin
    for (int m = 0; m < `NB_MASTER; m++)
    begin
      hit[m] = (slave_ar_i.addr >= start_addr_i[m]) && (slave_ar_i.addr <= end_addr_i[m]);
    end
  end

  assign miss = ~|hit;

  // One payload fans out to all arbiters, the request bit selects the target
  assign req_o    = slave_ar_valid_i ? hit : '0;
  assign req_ar_o = slave_ar_i;

  // Unmapped requests are taken only while the responder is idle
  assign slave_ar_ready_o = miss ? ~err_pending_q : |(gnt_i & hit);
  assign err_accept       = slave_ar_valid_i && miss && !err_pending_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      err_pending_q <= 1'b0;
    else if (err_accept)
      err_pending_q <= 1'b1;
    else if (err_r_ready_i)
      err_pending_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (err_accept)
      err_id_q <= slave_ar_i.id;
  end

  assign err_r_valid_o = err_pending_q;
  assign err_r_o.id    = err_id_q;
  assign err_r_o.data  = '0;
  assign err_r_o.resp  = DECERR;

  // Overlapping ranges in the memory map
  a_single_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
    slave_ar_valid_i |-> $onehot0(hit));

endmodule

/* axi_ar_arbiter.sv */
`include "axi_node_defines.svh"

module axi_ar_arbiter
#(
  parameter int SLAVE_IDX_W = axi_node_pkg::AXI_ID_WIDTH_INIT - `AXI_ID_WIDTH
)
(
  input  logic                                    clk,
  input  logic                                    rst_n_i,

  input  logic [`NB_SLAVE-1:0]                    req_i,
  input  axi_node_pkg::ar_targ_t [`NB_SLAVE-1:0]  req_ar_i,
  output logic [`NB_SLAVE-1:0]                    gnt_o,

  output logic                                    master_ar_valid_o,
  output axi_node_pkg::ar_init_t                  master_ar_o,
  input  logic                                    master_ar_ready_i
);

  import axi_node_pkg::*;

  logic [SLAVE_IDX_W-1:0] ptr_q;
  logic [SLAVE_IDX_W-1:0] lock_idx_q;
  logic                   lock_q;
  logic [SLAVE_IDX_W-1:0] pick;
  logic [SLAVE_IDX_W-1:0] win;
  logic [SLAVE_IDX_W-1:0] next_ptr;

  // Search starts at the port after the last winner
  always_comb
  begin
    int  idx;
    logic found;
    pick  = ptr_q;
    found = 1'b0;
    for (int k = 0; k < `NB_SLAVE; k++)
    begin
      idx = (int'(ptr_q) + k) % `NB_SLAVE;
      if (!found && req_i[idx])
      begin
        pick  = idx[SLAVE_IDX_W-1:0];
        found = 1'b1;
      end
    end
  end

  assign win      = lock_q ? lock_idx_q : pick;
  assign next_ptr = SLAVE_IDX_W'((int'(win) + 1) % `NB_SLAVE);

  assign master_ar_valid_o = |req_i;
  assign master_ar_o.id    = {win, req_ar_i[win].id};
  assign master_ar_o.addr  = req_ar_i[win].addr;

  always_comb
  begin
    gnt_o = '0;
    gnt_o[win] = master_ar_ready_i && req_i[win];
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end
    else
    begin
      lock_q     <= master_ar_valid_o && !master_ar_ready_i;
      lock_idx_q <= win;
      if (master_ar_valid_o && master_ar_ready_i)
        ptr_q <= next_ptr;
    end
  end

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    master_ar_valid_o && !master_ar_ready_i |=> master_ar_valid_o && $stable(master_ar_o));

endmodule

/* axi_r_router.sv */
`include "axi_node_defines.svh"

module axi_r_router
#(
  parameter int SLAVE_IDX = 0
)
(
  input  logic                                    clk,
  input  logic                                    rst_n_i,

  input  logic [`NB_MASTER-1:0]                   master_r_valid_i,
  input  axi_node_pkg::r_init_t [`NB_MASTER-1:0]  master_r_i,
  output logic [`NB_MASTER-1:0]                   r_gnt_o,

  input  logic                                    err_r_valid_i,
  input  axi_node_pkg::r_targ_t                   err_r_i,
  output logic                                    err_r_ready_o,

  output logic                                    slave_r_valid_o,
  output axi_node_pkg::r_targ_t                   slave_r_o,
  input  logic                                    slave_r_ready_i
);

  import axi_node_pkg::*;

  localparam int SLAVE_IDX_W = AXI_ID_WIDTH_INIT - `AXI_ID_WIDTH;
  localparam logic [SLAVE_IDX_W-1:0] PREFIX = SLAVE_IDX_W'(SLAVE_IDX);
  // Master ports plus the local DECERR channel at the top index
  localparam int NB_CAND = `NB_MASTER + 1;
  localparam int CAND_W  = $clog2(NB_CAND);

  logic [NB_CAND-1:0] cand;
  logic [CAND_W-1:0]  ptr_q;
  logic [CAND_W-1:0]  lock_idx_q;
  logic               lock_q;
  logic [CAND_W-1:0]  pick;
  logic [CAND_W-1:0]  win;

  always_comb
  begin
    for (int m = 0; m < `NB_MASTER; m++)
    begin
      cand[m] = master_r_valid_i[m] &&
                (master_r_i[m].id[AXI_ID_WIDTH_INIT-1 -: SLAVE_IDX_W] == PREFIX);
    end
    cand[`NB_MASTER] = err_r_valid_i;
  end

  always_comb
  begin
    int   idx;
    logic found;
    pick  = ptr_q;
    found = 1'b0;
    for (int k = 0; k < NB_CAND; k++)
    begin
      idx = (int'(ptr_q) + k) % NB_CAND;
      if (!found && cand[idx])
      begin
        pick  = idx[CAND_W-1:0];
        found = 1'b1;
      end
    end
  end

  assign win             = lock_q ? lock_idx_q : pick;
  assign slave_r_valid_o = |cand;

  // Strip the slave index from the ID on the way back
  always_comb
  begin
    slave_r_o = err_r_i;
    r_gnt_o   = '0;
    for (int m = 0; m < `NB_MASTER; m++)
    begin
      if (int'(win) == m)
      begin
        slave_r_o.id   = master_r_i[m].id[`AXI_ID_WIDTH-1:0];
        slave_r_o.data = master_r_i[m].data;
        slave_r_o.resp = master_r_i[m].resp;
        r_gnt_o[m]     = slave_r_ready_i && cand[m];
      end
    end
  end

  assign err_r_ready_o = slave_r_ready_i && cand[`NB_MASTER] && (int'(win) == `NB_MASTER);

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end
    else
    begin
      lock_q     <= slave_r_valid_o && !slave_r_ready_i;
      lock_idx_q <= win;
      if (slave_r_valid_o && slave_r_ready_i)
        ptr_q <= CAND_W'((int'(win) + 1) % NB_CAND);
    end
  end

  // The selected master port still holds a response for this slave port
  for (genvar m = 0; m < `NB_MASTER; m++)
  begin : g_prefix_chk
    a_prefix: assert property (@(posedge clk) disable iff (!rst_n_i)
      slave_r_valid_o && (int'(win) == m) |-> master_r_valid_i[m] &&
        (master_r_i[m].id[AXI_ID_WIDTH_INIT-1 -: SLAVE_IDX_W] == PREFIX));
  end

endmodule

/* axi_node_top.sv */
`include "axi_node_defines.svh"

module axi_node_top
(
  input  logic                                    clk,
  input  logic                                    rst_n_i,

  input  axi_node_pkg::addr_t [`NB_MASTER-1:0]    start_addr_i,
  input  axi_node_pkg::addr_t [`NB_MASTER-1:0]    end_addr_i,

  input  logic [`NB_SLAVE-1:0]                    slave_ar_valid_i,
  input  axi_node_pkg::ar_targ_t [`NB_SLAVE-1:0]  slave_ar_i,
  output logic [`NB_SLAVE-1:0]                    slave_ar_ready_o,
  output logic [`NB_SLAVE-1:0]                    slave_r_valid_o,
  output axi_node_pkg::r_targ_t [`NB_SLAVE-1:0]   slave_r_o,
  input  logic [`NB_SLAVE-1:0]                    slave_r_ready_i,

  output logic [`NB_MASTER-1:0]                   master_ar_valid_o,
  output axi_node_pkg::ar_init_t [`NB_MASTER-1:0] master_ar_o,
  input  logic [`NB_MASTER-1:0]                   master_ar_ready_i,
  input  logic [`NB_MASTER-1:0]                   master_r_valid_i,
  input  axi_node_pkg::r_init_t [`NB_MASTER-1:0]  master_r_i,
  output logic [`NB_MASTER-1:0]                   master_r_ready_o
);

  import axi_node_pkg::*;

  // Decoder side is indexed [slave][master], arbiter side [master][slave]
  logic [`NB_SLAVE-1:0][`NB_MASTER-1:0] dec_req;
  logic [`NB_SLAVE-1:0][`NB_MASTER-1:0] dec_gnt;
  logic [`NB_MASTER-1:0][`NB_SLAVE-1:0] arb_req;
  logic [`NB_MASTER-1:0][`NB_SLAVE-1:0] arb_gnt;
  ar_targ_t [`NB_SLAVE-1:0]             dec_ar;

  logic [`NB_SLAVE-1:0]                 err_valid;
  r_targ_t [`NB_SLAVE-1:0]              err_r;
  logic [`NB_SLAVE-1:0]                 err_ready;
  logic [`NB_SLAVE-1:0][`NB_MASTER-1:0] rtr_gnt;

  for (genvar s = 0; s < `NB_SLAVE; s++)
  begin : g_xpose_s
    for (genvar m = 0; m < `NB_MASTER; m++)
    begin : g_xpose_m
      assign arb_req[m][s] = dec_req[s][m];
      assign dec_gnt[s][m] = arb_gnt[m][s];
    end
  end

  for (genvar s = 0; s < `NB_SLAVE; s++)
  begin : g_slave
    axi_addr_decoder dec_i
    (
      .clk              ( clk                 ),
      .rst_n_i          ( rst_n_i             ),
      .start_addr_i     ( start_addr_i        ),
      .end_addr_i       ( end_addr_i          ),
      .slave_ar_valid_i ( slave_ar_valid_i[s] ),
      .slave_ar_i       ( slave_ar_i[s]       ),
      .slave_ar_ready_o ( slave_ar_ready_o[s] ),
      .req_o            ( dec_req[s]          ),
      .req_ar_o         ( dec_ar[s]           ),
      .gnt_i            ( dec_gnt[s]          ),
      .err_r_valid_o    ( err_valid[s]        ),
      .err_r_o          ( err_r[s]            ),
      .err_r_ready_i    ( err_ready[s]        )
    );

    axi_r_router #(.SLAVE_IDX(s)) rtr_i
    (
      .clk              ( clk                 ),
      .rst_n_i          ( rst_n_i             ),
      .master_r_valid_i ( master_r_valid_i    ),
      .master_r_i       ( master_r_i          ),
      .r_gnt_o          ( rtr_gnt[s]          ),
      .err_r_valid_i    ( err_valid[s]        ),
      .err_r_i          ( err_r[s]            ),
      .err_r_ready_o    ( err_ready[s]        ),
      .slave_r_valid_o  ( slave_r_valid_o[s]  ),
      .slave_r_o        ( slave_r_o[s]        ),
      .slave_r_ready_i  ( slave_r_ready_i[s]  )
    );
  end

  for (genvar m = 0; m < `NB_MASTER; m++)
  begin : g_master
    axi_ar_arbiter #(.SLAVE_IDX_W(AXI_ID_WIDTH_INIT - `AXI_ID_WIDTH)) arb_i
    (
      .clk               ( clk                  ),
      .rst_n_i           ( rst_n_i              ),
      .req_i             ( arb_req[m]           ),
      .req_ar_i          ( dec_ar               ),
      .gnt_o             ( arb_gnt[m]           ),
      .master_ar_valid_o ( master_ar_valid_o[m] ),
      .master_ar_o       ( master_ar_o[m]       ),
      .master_ar_ready_i ( master_ar_ready_i[m] )
    );
  end

  // Only the router owning the ID prefix ever grants a given response
  always_comb
  begin
    master_r_ready_o = '0;
    for (int s = 0; s < `NB_SLAVE; s++)
    begin
      master_r_ready_o = master_r_ready_o | rtr_gnt[s];
    end
  end

endmodule

/* tb_axi_node.sv */
`include "axi_node_defines.svh"

module tb_axi_node;

  import axi_node_pkg::*;

  localparam int NROWS      = 16;
  localparam int CLK_PERIOD = 4;

  // exp is the master port index, 3 marks an unmapped address
  typedef struct packed {
    logic                     port;
    logic [`AXI_ID_WIDTH-1:0] id;
    addr_t                    addr;
    logic [1:0]               exp;
    logic [1:0]               gap;
  } row_t;

  logic                             clk;
  logic                             rst_n_i;
  addr_t [`NB_MASTER-1:0]           start_addr_i;
  addr_t [`NB_MASTER-1:0]           end_addr_i;
  logic [`NB_SLAVE-1:0]             slave_ar_valid_i;
  ar_targ_t [`NB_SLAVE-1:0]         slave_ar_i;
  logic [`NB_SLAVE-1:0]             slave_ar_ready_o;
  logic [`NB_SLAVE-1:0]             slave_r_valid_o;
  r_targ_t [`NB_SLAVE-1:0]          slave_r_o;
  logic [`NB_SLAVE-1:0]             slave_r_ready_i;
  logic [`NB_MASTER-1:0]            master_ar_valid_o;
  ar_init_t [`NB_MASTER-1:0]        master_ar_o;
  logic [`NB_MASTER-1:0]            master_ar_ready_i;
  logic [`NB_MASTER-1:0]            master_r_valid_i;
  r_init_t [`NB_MASTER-1:0]         master_r_i;
  logic [`NB_MASTER-1:0]            master_r_ready_o;

  row_t                             rows [NROWS];
  int                               ar_seen [NROWS];
  int                               r_seen [NROWS];
  int                               cur [`NB_SLAVE];
  int                               next_row [`NB_SLAVE];
  int                               gap_cnt [`NB_SLAVE];
  int                               last_win [`NB_MASTER];
  logic [`NB_MASTER-1:0]            busy;
  logic [`NB_MASTER-1:0]            r_pend;
  logic [`NB_MASTER-1:0]            m_wait;
  logic [`NB_MASTER-1:0]            both_req;
  logic [`NB_MASTER-1:0][1:0]       r_delay;
  ar_init_t [`NB_MASTER-1:0]        held;
  ar_init_t [`NB_MASTER-1:0]        m_prev;
  logic [`NB_SLAVE-1:0]             s_wait;
  r_targ_t [`NB_SLAVE-1:0]          s_prev;
  logic [15:0]                      lfsr;
  int                               errors;
  int                               checks;
  int                               done_count;
  int                               alt_checks;

  axi_node_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  // IDs are unique per slave port over the whole table
  function automatic int lookup_row(input int p, input logic [`AXI_ID_WIDTH-1:0] id);
    int found;
    found = -1;
    for (int i = 0; i < NROWS; i++)
    begin
      if (int'(rows[i].port) == p && rows[i].id == id)
        found = i;
    end
    return found;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    assert (exp == act)
    else
    begin
      errors++;
      $display("ERR time %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic require_true(input logic ok, input string msg);
    checks++;
    assert (ok)
    else
    begin
      errors++;
      $display("Error at time %0t: %s", $time, msg);
    end
  endtask

  // Runs mid-cycle, so valid && ready here means a transfer at the next rising edge
  task automatic sample_cycle();
    int   r;
    int   src;
    logic [31:0] exp_data;
    for (int m = 0; m < `NB_MASTER; m++)
    begin
      if (m_wait[m])
      begin
        require_true(master_ar_valid_o[m], "master AR valid dropped before its handshake");
        compare_value("master_ar_o", 64'(m_prev[m]), 64'(master_ar_o[m]));
      end
      else
        both_req[m] = cur[0] >= 0 && cur[1] >= 0 && int'(rows[cur[0]].exp) == m &&
                      int'(rows[cur[1]].exp) == m;
      m_wait[m] = master_ar_valid_o[m] && !master_ar_ready_i[m];
      m_prev[m] = master_ar_o[m];
      if (r_pend[m] && master_r_ready_o[m])
      begin
        busy[m]   = 1'b0;
        r_pend[m] = 1'b0;
      end
      else if (busy[m] && !r_pend[m])
      begin
        r_delay[m] = r_delay[m] - 2'd1;
        r_pend[m]  = (r_delay[m] == 2'd0);
      end
      if (master_ar_valid_o[m] && master_ar_ready_i[m])
      begin
        src = int'(master_ar_o[m].id >> `AXI_ID_WIDTH);
        r   = lookup_row(src, master_ar_o[m].id[`AXI_ID_WIDTH-1:0]);
        require_true(r >= 0, "AR at a master port matches no issued request");
        if (r >= 0)
        begin
          require_true(int'(rows[r].exp) == m, "read appeared on a master port outside its range");
          compare_value("master_ar_o.addr", 64'(rows[r].addr), 64'(master_ar_o[m].addr));
          ar_seen[r]++;
          require_true(ar_seen[r] == 1, "read forwarded to a master port more than once");
        end
        if (both_req[m] && last_win[m] >= 0)
        begin
          alt_checks++;
          require_true(src != last_win[m], "same slave port granted twice in a row under contention");
        end
        last_win[m] = src;
        busy[m]     = 1'b1;
        held[m]     = master_ar_o[m];
        r_delay[m]  = {rand_bit(), rand_bit()};
        r_pend[m]   = (r_delay[m] == 2'd0);
      end
    end
    for (int p = 0; p < `NB_SLAVE; p++)
    begin
      if (s_wait[p])
      begin
        require_true(slave_r_valid_o[p], "slave R valid dropped before its handshake");
        compare_value("slave_r_o", 64'(s_prev[p]), 64'(slave_r_o[p]));
      end
      s_wait[p] = slave_r_valid_o[p] && !slave_r_ready_i[p];
      s_prev[p] = slave_r_o[p];
      if (slave_r_valid_o[p] && slave_r_ready_i[p])
      begin
        r = lookup_row(p, slave_r_o[p].id);
        require_true(r >= 0, "response at a slave port matches no issued request");
        if (r >= 0)
        begin
          exp_data = (rows[r].exp == 2'd3) ? 32'h0 : ~rows[r].addr;
          compare_value("slave_r_o.data", 64'(exp_data), 64'(slave_r_o[p].data));
          if (rows[r].exp == 2'd3)
            compare_value("slave_r_o.resp", 64'(DECERR), 64'(slave_r_o[p].resp));
          else
            compare_value("slave_r_o.resp", 64'(OKAY), 64'(slave_r_o[p].resp));
          require_true(rows[r].exp == 2'd3 || ar_seen[r] == 1, "response for a read never forwarded");
          r_seen[r]++;
          require_true(r_seen[r] == 1, "read completed more than once");
        end
        done_count++;
      end
      if (slave_ar_valid_i[p] && slave_ar_ready_o[p])
        cur[p] = -1;
    end
  endtask

  task automatic drive_inputs();
    for (int p = 0; p < `NB_SLAVE; p++)
    begin
      if (cur[p] < 0)
      begin
        while (next_row[p] < NROWS && int'(rows[next_row[p]].port) != p)
          next_row[p]++;
        if (next_row[p] < NROWS && gap_cnt[p] >= int'(rows[next_row[p]].gap))
        begin
          cur[p]     = next_row[p];
          next_row[p]++;
          gap_cnt[p] = 0;
        end
        else if (next_row[p] < NROWS)
          gap_cnt[p]++;
      end
      slave_ar_valid_i[p] = cur[p] >= 0;
      if (cur[p] >= 0)
      begin
        slave_ar_i[p].id   = rows[cur[p]].id;
        slave_ar_i[p].addr = rows[cur[p]].addr;
      end
      slave_r_ready_i[p] = rand_bit();
    end
    // Each peripheral holds one read at a time
    for (int m = 0; m < `NB_MASTER; m++)
    begin
      master_ar_ready_i[m]  = !busy[m] && rand_bit();
      master_r_valid_i[m]   = r_pend[m];
      master_r_i[m].id      = held[m].id;
      master_r_i[m].data    = ~held[m].addr;
      master_r_i[m].resp    = OKAY;
    end
  endtask

  initial
  begin
    #(NROWS * 40 * CLK_PERIOD);
    $display("Timeout: only %0d of %0d reads completed", done_count, NROWS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    rst_n_i = 1'b0;
    start_addr_i = {32'h4000_0000, 32'h1000_0000, 32'h0000_0000};
    end_addr_i   = {32'h4FFF_FFFF, 32'h1FFF_FFFF, 32'h0FFF_FFFF};
    slave_ar_valid_i = '0;
    slave_ar_i = '0;
    slave_r_ready_i = '0;
    master_ar_ready_i = '0;
    master_r_valid_i = '0;
    master_r_i = '0;
    {busy, r_pend, m_wait, both_req, r_delay, held, m_prev, s_wait, s_prev} = '0;
    {errors, checks, done_count, alt_checks} = '0;
    lfsr = 16'd37070;
    for (int i = 0; i < `NB_SLAVE; i++)
    begin
      cur[i] = -1;
      next_row[i] = 0;
      gap_cnt[i] = 0;
    end
    for (int i = 0; i < `NB_MASTER; i++)
      last_win[i] = -1;
    // Rows 0 to 5 make both slave ports compete for master port 0
    rows[0]  = '{1'b0, 4'h1, 32'h0000_0100, 2'd0, 2'd0};
    rows[1]  = '{1'b1, 4'h2, 32'h0000_0200, 2'd0, 2'd0};
    rows[2]  = '{1'b0, 4'h3, 32'h0000_0300, 2'd0, 2'd0};
    rows[3]  = '{1'b1, 4'h4, 32'h0000_0400, 2'd0, 2'd0};
    rows[4]  = '{1'b0, 4'h5, 32'h0000_0500, 2'd0, 2'd0};
    rows[5]  = '{1'b1, 4'h6, 32'h0FFF_FFFC, 2'd0, 2'd0};
    rows[6]  = '{1'b0, 4'h7, 32'h1000_0000, 2'd1, 2'd1};
    rows[7]  = '{1'b1, 4'h8, 32'h1FFF_FFF0, 2'd1, 2'd0};
    rows[8]  = '{1'b0, 4'h9, 32'h2000_0000, 2'd3, 2'd2};
    rows[9]  = '{1'b1, 4'hA, 32'h4000_0040, 2'd2, 2'd0};
    rows[10] = '{1'b0, 4'hB, 32'h4FFF_FFFC, 2'd2, 2'd0};
    rows[11] = '{1'b1, 4'hC, 32'h8000_0010, 2'd3, 2'd1};
    rows[12] = '{1'b0, 4'hD, 32'h3FFF_FFFC, 2'd3, 2'd0};
    rows[13] = '{1'b1, 4'hE, 32'h1000_0E00, 2'd1, 2'd3};
    rows[14] = '{1'b0, 4'hF, 32'h5000_0000, 2'd3, 2'd0};
    rows[15] = '{1'b1, 4'h0, 32'h0000_0F00, 2'd0, 2'd0};
    for (int i = 0; i < NROWS; i++)
    begin
      ar_seen[i] = 0;
      r_seen[i] = 0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    while (done_count < NROWS)
    begin
      drive_inputs();
      @(negedge clk);
      sample_cycle();
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < NROWS; i++)
      require_true(r_seen[i] == 1, "a table row did not complete exactly once");
    require_true(alt_checks > 0, "no contended arbitration was observed");
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
axi_node_pkg.sv
axi_addr_decoder.sv
axi_ar_arbiter.sv
axi_r_router.sv
axi_node_top.sv
tb_axi_node.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_axi_node -o sim_tb_axi_node

out=$(./obj_dir/sim_tb_axi_node)
echo "$out"

if grep -q "Regression passed" <<< "$out"; then
  exit 0
fi
exit 1
